/* eth_dma_params.svh */
`ifndef ETH_DMA_PARAMS_SVH
`define ETH_DMA_PARAMS_SVH

// Memory and bus widths
`define ETH_BD_ADDR_W      8
`define ETH_BUF_ADDR_W     11
`define ETH_AXI_ADDR_W     32
`define ETH_AXI_DATA_W     32
`define ETH_AXI_LEN_W      8
`define ETH_MAX_BURST      16

// Ethernet framing
`define ETH_PREAMBLE       8'h55
`define ETH_SFD            8'hd5
`define ETH_PREAMBLE_LEN   7
`define ETH_PRE_FRAME_LEN  8

// Descriptor control word bits
`define ETH_BD_LEN_LSB     16
`define ETH_BD_READY       15
`define ETH_BD_IRQ         14
`define ETH_BD_WRAP        13
`define ETH_BD_CRC         11
`define ETH_BD_CRC_ERR     1

`endif

/* eth_dma_pkg.sv */
`default_nettype none

`include "eth_dma_params.svh"

package eth_dma_pkg;

   // One ring index covers two descriptor words
   typedef logic [`ETH_BD_ADDR_W-2:0]  bd_num_t;
   typedef logic [`ETH_BD_ADDR_W-1:0]  bd_addr_t;
   typedef logic [`ETH_BUF_ADDR_W-1:0] buf_addr_t;

   typedef enum logic [2:0] {
      TX_PREAMBLE,
      TX_REQ_BD,
      TX_READ_BD,
      TX_REQ_PTR,
      TX_READ_PTR,
      TX_BURST_ADDR,
      TX_BURST_DATA,
      TX_STATUS
   } tx_state_e;

   typedef enum logic [2:0] {
      RX_REQ_BD,
      RX_READ_BD,
      RX_REQ_PTR,
      RX_READ_PTR,
      RX_BURST_ADDR,
      RX_FETCH,
      RX_BURST_DATA,
      RX_STATUS
   } rx_state_e;

endpackage

`default_nettype wire

/* eth_bd_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module eth_bd_arbiter (
   input  logic                  clk_i,
   input  logic                  arst_i,
   input  logic                  tx_req_i,
   input  logic                  rx_req_i,
   input  eth_dma_pkg::bd_addr_t tx_addr_i,
   input  eth_dma_pkg::bd_addr_t rx_addr_i,
   input  logic                  tx_wen_i,
   input  logic                  rx_wen_i,
   input  logic [31:0]           tx_wdata_i,
   input  logic [31:0]           rx_wdata_i,
   output logic                  tx_gnt_o,
   output logic                  rx_gnt_o,
   output eth_dma_pkg::bd_addr_t bd_addr_o,
   output logic                  bd_wen_o,
   output logic [31:0]           bd_wdata_o
);

   // High when the receive channel won the last grant
   logic last_rx_q;

   always_comb begin
      tx_gnt_o = tx_req_i;
      rx_gnt_o = rx_req_i;
      // Both asking, so the one that lost last time goes first
      if (tx_req_i && rx_req_i) begin
         tx_gnt_o = last_rx_q;
         rx_gnt_o = !last_rx_q;
      end
   end

   always_ff @(posedge clk_i) begin
      if (arst_i) begin
         last_rx_q <= 1'b0;
      end else if (tx_gnt_o) begin
         last_rx_q <= 1'b0;
      end else if (rx_gnt_o) begin
         last_rx_q <= 1'b1;
      end
   end

   // Memory port follows the winner
   assign bd_addr_o  = rx_gnt_o ? rx_addr_i : tx_addr_i;
   assign bd_wdata_o = rx_gnt_o ? rx_wdata_i : tx_wdata_i;
   assign bd_wen_o   = (tx_gnt_o && tx_wen_i) || (rx_gnt_o && rx_wen_i);

endmodule

`default_nettype wire

/* eth_tx_dma.sv */
`timescale 1ns/1ps
`default_nettype none

`include "eth_dma_params.svh"

module eth_tx_dma (
   input  logic                       clk_i,
   input  logic                       arst_i,
   input  logic                       tx_en_i,
   input  eth_dma_pkg::bd_num_t       tx_bd_num_i,
   input  logic                       bd_gnt_i,
   input  logic [31:0]                bd_rdata_i,
   input  logic                       tx_ready_i,
   input  logic                       axi_arready_i,
   input  logic                       axi_rvalid_i,
   input  logic [`ETH_AXI_DATA_W-1:0] axi_rdata_i,
   input  logic                       axi_rlast_i,
   output logic                       bd_req_o,
   output eth_dma_pkg::bd_addr_t      bd_addr_o,
   output logic                       bd_wen_o,
   output logic [31:0]                bd_wdata_o,
   output logic                       tx_buf_wen_o,
   output eth_dma_pkg::buf_addr_t     tx_buf_addr_o,
   output logic [7:0]                 tx_buf_wdata_o,
   output logic                       send_o,
   output logic                       crc_en_o,
   output logic [`ETH_BUF_ADDR_W-1:0] tx_nbytes_o,
   output logic [`ETH_AXI_ADDR_W-1:0] axi_araddr_o,
   output logic [`ETH_AXI_LEN_W-1:0]  axi_arlen_o,
   output logic                       axi_arvalid_o,
   output logic                       axi_rready_o,
   output logic                       tx_irq_o
);

   import eth_dma_pkg::*;

   tx_state_e                  state_q;
   bd_num_t                    bd_idx_q;
   bd_addr_t                   bd_idx_inc;
   logic                       last_bd;
   logic [31:0]                ctrl_q;
   logic [`ETH_AXI_ADDR_W-1:0] ptr_q;
   logic [15:0]                byte_cnt_q;
   logic [15:0]                bytes_left;
   logic                       frame_done;
   logic [`ETH_AXI_ADDR_W-1:0] rd_addr;
   logic [1:0]                 lane;

   assign bytes_left = ctrl_q[31:`ETH_BD_LEN_LSB] - byte_cnt_q;
   assign frame_done = (bytes_left == 16'd0);
   assign rd_addr    = ptr_q + `ETH_AXI_ADDR_W'(byte_cnt_q);
   assign lane       = rd_addr[1:0];

   // Ring wraps on the wrap bit or past the last transmit entry
   assign bd_idx_inc = {1'b0, bd_idx_q} + 1'b1;
   assign last_bd    = ctrl_q[`ETH_BD_WRAP] || (bd_idx_inc >= {1'b0, tx_bd_num_i});

   assign axi_araddr_o  = rd_addr;
   assign axi_arlen_o   = (bytes_left >= `ETH_MAX_BURST) ?
                          `ETH_AXI_LEN_W'(`ETH_MAX_BURST - 1) :
                          `ETH_AXI_LEN_W'(bytes_left - 16'd1);
   assign axi_arvalid_o = (state_q == TX_BURST_ADDR) && !frame_done;
   assign axi_rready_o  = (state_q == TX_BURST_DATA);

   assign tx_irq_o   = (state_q == TX_STATUS) && bd_gnt_i && ctrl_q[`ETH_BD_IRQ];
   assign bd_wdata_o = ctrl_q;

   // Descriptor memory requests
   always_comb begin
      bd_req_o  = 1'b0;
      bd_wen_o  = 1'b0;
      bd_addr_o = {bd_idx_q, 1'b0};
      case (state_q)
         TX_REQ_BD: bd_req_o = 1'b1;
         TX_REQ_PTR: begin
            bd_req_o  = 1'b1;
            bd_addr_o = {bd_idx_q, 1'b1};
         end
         TX_STATUS: begin
            bd_req_o = 1'b1;
            bd_wen_o = 1'b1;
         end
         default: ;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (arst_i) begin
         state_q      <= TX_PREAMBLE;
         bd_idx_q     <= '0;
         byte_cnt_q   <= '0;
         tx_buf_wen_o <= 1'b0;
         send_o       <= 1'b0;
         crc_en_o     <= 1'b0;
         tx_nbytes_o  <= '0;
      end else begin
         tx_buf_wen_o <= 1'b0;
         send_o       <= 1'b0;
         case (state_q)
            TX_PREAMBLE: begin
               tx_buf_wen_o <= 1'b1;
               byte_cnt_q   <= byte_cnt_q + 16'd1;
               if (byte_cnt_q == `ETH_PRE_FRAME_LEN - 1) begin
                  byte_cnt_q <= '0;
                  state_q    <= TX_REQ_BD;
               end
            end
            TX_REQ_BD: begin
               if (bd_gnt_i) state_q <= TX_READ_BD;
            end
            TX_READ_BD: begin
               // Poll until software hands over the descriptor
               if (bd_rdata_i[`ETH_BD_READY] && tx_en_i) state_q <= TX_REQ_PTR;
               else state_q <= TX_REQ_BD;
            end
            TX_REQ_PTR: begin
               if (bd_gnt_i) state_q <= TX_READ_PTR;
            end
            TX_READ_PTR: begin
               byte_cnt_q <= '0;
               if (tx_ready_i) state_q <= TX_BURST_ADDR;
               else state_q <= TX_REQ_PTR;
            end
            TX_BURST_ADDR: begin
               if (frame_done) begin
                  send_o      <= 1'b1;
                  crc_en_o    <= ctrl_q[`ETH_BD_CRC];
                  tx_nbytes_o <= ctrl_q[`ETH_BD_LEN_LSB +: `ETH_BUF_ADDR_W] + `ETH_PRE_FRAME_LEN;
                  state_q     <= TX_STATUS;
               end else if (axi_arready_i) begin
                  state_q <= TX_BURST_DATA;
               end
            end
            TX_BURST_DATA: begin
               if (axi_rvalid_i) begin
                  tx_buf_wen_o <= 1'b1;
                  byte_cnt_q   <= byte_cnt_q + 16'd1;
                  if (axi_rlast_i) state_q <= TX_BURST_ADDR;
               end
            end
            TX_STATUS: begin
               if (bd_gnt_i) begin
                  bd_idx_q <= last_bd ? '0 : bd_idx_inc[`ETH_BD_ADDR_W-2:0];
                  state_q  <= TX_REQ_BD;
               end
            end
            default: state_q <= TX_REQ_BD;
         endcase
      end
   end

   // Descriptor copy and frame buffer write data
   always_ff @(posedge clk_i) begin
      if (state_q == TX_READ_BD) ctrl_q <= bd_rdata_i;
      if (state_q == TX_BURST_ADDR && frame_done) ctrl_q[`ETH_BD_READY] <= 1'b0;
      if (state_q == TX_READ_PTR) ptr_q <= bd_rdata_i;
      if (state_q == TX_PREAMBLE) begin
         tx_buf_addr_o  <= `ETH_BUF_ADDR_W'(byte_cnt_q);
         tx_buf_wdata_o <= (byte_cnt_q == `ETH_PREAMBLE_LEN) ? `ETH_SFD : `ETH_PREAMBLE;
      end else begin
         // Payload starts right after the SFD
         tx_buf_addr_o  <= `ETH_BUF_ADDR_W'(byte_cnt_q + `ETH_PRE_FRAME_LEN);
         tx_buf_wdata_o <= axi_rdata_i[{lane, 3'b000} +: 8];
      end
   end

endmodule

`default_nettype wire

/* eth_rx_dma.sv */
`timescale 1ns/1ps
`default_nettype none

`include "eth_dma_params.svh"

module eth_rx_dma (
   input  logic                           clk_i,
   input  logic                           arst_i,
   input  logic                           rx_en_i,
   input  eth_dma_pkg::bd_num_t           tx_bd_num_i,
   input  logic                           bd_gnt_i,
   input  logic [31:0]                    bd_rdata_i,
   input  logic                           rx_data_rcvd_i,
   input  logic [`ETH_BUF_ADDR_W-1:0]     rx_nbytes_i,
   input  logic                           crc_err_i,
   input  logic [7:0]                     rx_buf_rdata_i,
   input  logic                           axi_awready_i,
   input  logic                           axi_wready_i,
   output logic                           bd_req_o,
   output eth_dma_pkg::bd_addr_t          bd_addr_o,
   output logic                           bd_wen_o,
   output logic [31:0]                    bd_wdata_o,
   output eth_dma_pkg::buf_addr_t         rx_buf_addr_o,
   output logic                           rcv_ack_o,
   output logic [`ETH_AXI_ADDR_W-1:0]     axi_awaddr_o,
   output logic [`ETH_AXI_LEN_W-1:0]      axi_awlen_o,
   output logic                           axi_awvalid_o,
   output logic                           axi_wvalid_o,
   output logic [`ETH_AXI_DATA_W/8-1:0]   axi_wstrb_o,
   output logic [`ETH_AXI_DATA_W-1:0]     axi_wdata_o,
   output logic                           axi_wlast_o,
   output logic                           rx_irq_o
);

   import eth_dma_pkg::*;

   rx_state_e                  state_q;
   bd_num_t                    bd_idx_q;
   logic                       last_bd;
   logic [31:0]                ctrl_q;
   logic [`ETH_AXI_ADDR_W-1:0] ptr_q;
   logic [15:0]                byte_cnt_q;
   logic [15:0]                bytes_left;
   logic                       frame_done;
   logic [`ETH_AXI_LEN_W-1:0]  beat_q;
   logic [`ETH_AXI_LEN_W-1:0]  burst_last_q;
   logic                       beat_fire;
   logic [15:0]                rd_cnt;
   logic [`ETH_AXI_ADDR_W-1:0] wr_addr;
   logic [1:0]                 lane;

   assign bytes_left = 16'(rx_nbytes_i) - byte_cnt_q;
   assign frame_done = (bytes_left == 16'd0);
   assign wr_addr    = ptr_q + `ETH_AXI_ADDR_W'(byte_cnt_q);
   assign lane       = wr_addr[1:0];
   assign beat_fire  = axi_wvalid_o && axi_wready_i;

   // Receive ring spans tx_bd_num_i up to the top entry
   assign last_bd = ctrl_q[`ETH_BD_WRAP] || (bd_idx_q == '1);

   // Read ahead on an accepted beat so the next byte is ready in time
   assign rd_cnt        = byte_cnt_q + 16'(beat_fire);
   assign rx_buf_addr_o = rd_cnt[`ETH_BUF_ADDR_W-1:0];

   assign axi_awaddr_o  = wr_addr;
   assign axi_awlen_o   = (bytes_left >= `ETH_MAX_BURST) ?
                          `ETH_AXI_LEN_W'(`ETH_MAX_BURST - 1) :
                          `ETH_AXI_LEN_W'(bytes_left - 16'd1);
   assign axi_awvalid_o = (state_q == RX_BURST_ADDR) && !frame_done;
   assign axi_wvalid_o  = (state_q == RX_BURST_DATA);
   assign axi_wstrb_o   = (`ETH_AXI_DATA_W/8)'(1) << lane;
   assign axi_wdata_o   = `ETH_AXI_DATA_W'(rx_buf_rdata_i) << {lane, 3'b000};
   assign axi_wlast_o   = (beat_q == burst_last_q);

   assign rcv_ack_o  = (state_q == RX_BURST_ADDR) && frame_done;
   assign rx_irq_o   = (state_q == RX_STATUS) && bd_gnt_i && ctrl_q[`ETH_BD_IRQ];
   assign bd_wdata_o = ctrl_q;

   always_comb begin
      bd_req_o  = 1'b0;
      bd_wen_o  = 1'b0;
      bd_addr_o = {bd_idx_q, 1'b0};
      case (state_q)
         RX_REQ_BD: bd_req_o = 1'b1;
         RX_REQ_PTR: begin
            bd_req_o  = 1'b1;
            bd_addr_o = {bd_idx_q, 1'b1};
         end
         RX_STATUS: begin
            bd_req_o = 1'b1;
            bd_wen_o = 1'b1;
         end
         default: ;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (arst_i) begin
         state_q    <= RX_REQ_BD;
         bd_idx_q   <= tx_bd_num_i;
         byte_cnt_q <= '0;
         beat_q     <= '0;
      end else begin
         case (state_q)
            RX_REQ_BD: begin
               if (bd_gnt_i) state_q <= RX_READ_BD;
            end
            RX_READ_BD: begin
               if (bd_rdata_i[`ETH_BD_READY] && rx_en_i) state_q <= RX_REQ_PTR;
               else state_q <= RX_REQ_BD;
            end
            RX_REQ_PTR: begin
               if (bd_gnt_i) state_q <= RX_READ_PTR;
            end
            RX_READ_PTR: begin
               // Wait here for the MAC to hold a frame
               byte_cnt_q <= '0;
               if (rx_data_rcvd_i) state_q <= RX_BURST_ADDR;
               else state_q <= RX_REQ_PTR;
            end
            RX_BURST_ADDR: begin
               if (frame_done) begin
                  state_q <= RX_STATUS;
               end else if (axi_awready_i) begin
                  beat_q  <= '0;
                  state_q <= RX_FETCH;
               end
            end
            RX_FETCH: state_q <= RX_BURST_DATA;
            RX_BURST_DATA: begin
               if (axi_wready_i) begin
                  byte_cnt_q <= byte_cnt_q + 16'd1;
                  beat_q     <= beat_q + 1'b1;
                  if (axi_wlast_o) state_q <= RX_BURST_ADDR;
               end
            end
            RX_STATUS: begin
               if (bd_gnt_i) begin
                  bd_idx_q <= last_bd ? tx_bd_num_i : bd_idx_q + 1'b1;
                  state_q  <= RX_REQ_BD;
               end
            end
            default: state_q <= RX_REQ_BD;
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (state_q == RX_READ_BD) ctrl_q <= bd_rdata_i;
      if (state_q == RX_READ_PTR) ptr_q <= bd_rdata_i;
      if (axi_awvalid_o && axi_awready_i) burst_last_q <= axi_awlen_o;
      // Status word with length and CRC result
      if (rcv_ack_o) begin
         ctrl_q[31:`ETH_BD_LEN_LSB] <= 16'(rx_nbytes_i);
         ctrl_q[`ETH_BD_READY]      <= 1'b0;
         ctrl_q[`ETH_BD_CRC_ERR]    <= crc_err_i;
      end
   end

endmodule

`default_nettype wire

/* eth_dma.sv */
`timescale 1ns/1ps
`default_nettype none

`include "eth_dma_params.svh"

module eth_dma (
   input  logic                           clk_i,
   input  logic                           arst_i,
   input  logic                           tx_en_i,
   input  logic                           rx_en_i,
   input  eth_dma_pkg::bd_num_t           tx_bd_num_i,
   // Descriptor memory
   output eth_dma_pkg::bd_addr_t          bd_addr_o,
   output logic                           bd_wen_o,
   output logic [31:0]                    bd_wdata_o,
   input  logic [31:0]                    bd_rdata_i,
   // Transmit side of the MAC
   output logic                           tx_buf_wen_o,
   output eth_dma_pkg::buf_addr_t         tx_buf_addr_o,
   output logic [7:0]                     tx_buf_wdata_o,
   input  logic                           tx_ready_i,
   output logic                           send_o,
   output logic                           crc_en_o,
   output logic [`ETH_BUF_ADDR_W-1:0]     tx_nbytes_o,
   // Receive side of the MAC
   output eth_dma_pkg::buf_addr_t         rx_buf_addr_o,
   input  logic [7:0]                     rx_buf_rdata_i,
   input  logic                           rx_data_rcvd_i,
   input  logic [`ETH_BUF_ADDR_W-1:0]     rx_nbytes_i,
   input  logic                           crc_err_i,
   output logic                           rcv_ack_o,
   // AXI read
   output logic [`ETH_AXI_ADDR_W-1:0]     axi_araddr_o,
   output logic [`ETH_AXI_LEN_W-1:0]      axi_arlen_o,
   output logic                           axi_arvalid_o,
   input  logic                           axi_arready_i,
   input  logic [`ETH_AXI_DATA_W-1:0]     axi_rdata_i,
   input  logic                           axi_rvalid_i,
   input  logic                           axi_rlast_i,
   output logic                           axi_rready_o,
   // AXI write
   output logic [`ETH_AXI_ADDR_W-1:0]     axi_awaddr_o,
   output logic [`ETH_AXI_LEN_W-1:0]      axi_awlen_o,
   output logic                           axi_awvalid_o,
   input  logic                           axi_awready_i,
   output logic [`ETH_AXI_DATA_W-1:0]     axi_wdata_o,
   output logic [`ETH_AXI_DATA_W/8-1:0]   axi_wstrb_o,
   output logic                           axi_wlast_o,
   output logic                           axi_wvalid_o,
   input  logic                           axi_wready_i,
   output logic                           axi_bready_o,
   output logic                           tx_irq_o,
   output logic                           rx_irq_o
);

   import eth_dma_pkg::*;

   logic        tx_bd_req;
   logic        tx_bd_gnt;
   bd_addr_t    tx_bd_addr;
   logic        tx_bd_wen;
   logic [31:0] tx_bd_wdata;
   logic        rx_bd_req;
   logic        rx_bd_gnt;
   bd_addr_t    rx_bd_addr;
   logic        rx_bd_wen;
   logic [31:0] rx_bd_wdata;

   // Write responses are always accepted
   assign axi_bready_o = 1'b1;

   eth_bd_arbiter u_arbiter (
      .clk_i      (clk_i),
      .arst_i     (arst_i),
      .tx_req_i   (tx_bd_req),
      .rx_req_i   (rx_bd_req),
      .tx_addr_i  (tx_bd_addr),
      .rx_addr_i  (rx_bd_addr),
      .tx_wen_i   (tx_bd_wen),
      .rx_wen_i   (rx_bd_wen),
      .tx_wdata_i (tx_bd_wdata),
      .rx_wdata_i (rx_bd_wdata),
      .tx_gnt_o   (tx_bd_gnt),
      .rx_gnt_o   (rx_bd_gnt),
      .bd_addr_o  (bd_addr_o),
      .bd_wen_o   (bd_wen_o),
      .bd_wdata_o (bd_wdata_o)
   );

   eth_tx_dma u_tx_dma (
      .clk_i          (clk_i),
      .arst_i         (arst_i),
      .tx_en_i        (tx_en_i),
      .tx_bd_num_i    (tx_bd_num_i),
      .bd_gnt_i       (tx_bd_gnt),
      .bd_rdata_i     (bd_rdata_i),
      .tx_ready_i     (tx_ready_i),
      .axi_arready_i  (axi_arready_i),
      .axi_rvalid_i   (axi_rvalid_i),
      .axi_rdata_i    (axi_rdata_i),
      .axi_rlast_i    (axi_rlast_i),
      .bd_req_o       (tx_bd_req),
      .bd_addr_o      (tx_bd_addr),
      .bd_wen_o       (tx_bd_wen),
      .bd_wdata_o     (tx_bd_wdata),
      .tx_buf_wen_o   (tx_buf_wen_o),
      .tx_buf_addr_o  (tx_buf_addr_o),
      .tx_buf_wdata_o (tx_buf_wdata_o),
      .send_o         (send_o),
      .crc_en_o       (crc_en_o),
      .tx_nbytes_o    (tx_nbytes_o),
      .axi_araddr_o   (axi_araddr_o),
      .axi_arlen_o    (axi_arlen_o),
      .axi_arvalid_o  (axi_arvalid_o),
      .axi_rready_o   (axi_rready_o),
      .tx_irq_o       (tx_irq_o)
   );

   eth_rx_dma u_rx_dma (
      .clk_i          (clk_i),
      .arst_i         (arst_i),
      .rx_en_i        (rx_en_i),
      .tx_bd_num_i    (tx_bd_num_i),
      .bd_gnt_i       (rx_bd_gnt),
      .bd_rdata_i     (bd_rdata_i),
      .rx_data_rcvd_i (rx_data_rcvd_i),
      .rx_nbytes_i    (rx_nbytes_i),
      .crc_err_i      (crc_err_i),
      .rx_buf_rdata_i (rx_buf_rdata_i),
      .axi_awready_i  (axi_awready_i),
      .axi_wready_i   (axi_wready_i),
      .bd_req_o       (rx_bd_req),
      .bd_addr_o      (rx_bd_addr),
      .bd_wen_o       (rx_bd_wen),
      .bd_wdata_o     (rx_bd_wdata),
      .rx_buf_addr_o  (rx_buf_addr_o),
      .rcv_ack_o      (rcv_ack_o),
      .axi_awaddr_o   (axi_awaddr_o),
      .axi_awlen_o    (axi_awlen_o),
      .axi_awvalid_o  (axi_awvalid_o),
      .axi_wvalid_o   (axi_wvalid_o),
      .axi_wstrb_o    (axi_wstrb_o),
      .axi_wdata_o    (axi_wdata_o),
      .axi_wlast_o    (axi_wlast_o),
      .rx_irq_o       (rx_irq_o)
   );

endmodule

`default_nettype wire

/* eth_dma_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "eth_dma_params.svh"

module eth_dma_tb;

   localparam int TIMEOUT = 20000;
   localparam int TX_BDS  = 4;

   logic                           clk_i = 1'b0;
   logic                           arst_i;
   logic                           tx_en_i;
   logic                           rx_en_i;
   logic [`ETH_BD_ADDR_W-2:0]      tx_bd_num_i;
   logic [`ETH_BD_ADDR_W-1:0]      bd_addr_o;
   logic                           bd_wen_o;
   logic [31:0]                    bd_wdata_o;
   logic [31:0]                    bd_rdata_i;
   logic                           tx_buf_wen_o;
   logic [`ETH_BUF_ADDR_W-1:0]     tx_buf_addr_o;
   logic [7:0]                     tx_buf_wdata_o;
   logic                           tx_ready_i;
   logic                           send_o;
   logic                           crc_en_o;
   logic [`ETH_BUF_ADDR_W-1:0]     tx_nbytes_o;
   logic [`ETH_BUF_ADDR_W-1:0]     rx_buf_addr_o;
   logic [7:0]                     rx_buf_rdata_i;
   logic                           rx_data_rcvd_i;
   logic [`ETH_BUF_ADDR_W-1:0]     rx_nbytes_i;
   logic                           crc_err_i;
   logic                           rcv_ack_o;
   logic [`ETH_AXI_ADDR_W-1:0]     axi_araddr_o;
   logic [`ETH_AXI_LEN_W-1:0]      axi_arlen_o;
   logic                           axi_arvalid_o;
   logic                           axi_arready_i;
   logic [`ETH_AXI_DATA_W-1:0]     axi_rdata_i;
   logic                           axi_rvalid_i;
   logic                           axi_rlast_i;
   logic                           axi_rready_o;
   logic [`ETH_AXI_ADDR_W-1:0]     axi_awaddr_o;
   logic [`ETH_AXI_LEN_W-1:0]      axi_awlen_o;
   logic                           axi_awvalid_o;
   logic                           axi_awready_i;
   logic [`ETH_AXI_DATA_W-1:0]     axi_wdata_o;
   logic [`ETH_AXI_DATA_W/8-1:0]   axi_wstrb_o;
   logic                           axi_wlast_o;
   logic                           axi_wvalid_o;
   logic                           axi_wready_i;
   logic                           axi_bready_o;
   logic                           tx_irq_o;
   logic                           rx_irq_o;

   logic [7:0]  sys_mem [0:4095];
   logic [7:0]  wr_mem  [0:4095];
   logic [7:0]  tx_buf  [0:2047];
   logic [7:0]  rx_buf  [0:2047];
   logic [31:0] bd_mem  [0:255];

   int          send_cnt = 0;
   int          ack_cnt = 0;
   int          tx_irq_cnt = 0;
   int          rx_irq_cnt = 0;
   int          cycles = 0;
   int          err_cnt = 0;
   int          test_err = 0;
   int          test_cnt = 0;
   int          fail_cnt = 0;
   string       test_name = "reset";
   logic [`ETH_BUF_ADDR_W-1:0] last_nbytes;
   logic        last_crc;

   // Frame in flight on each channel
   int          tx_bd, tx_len, send0, tx_irq0;
   logic [31:0] tx_ptr, tx_ctrl;
   int          rx_bd, rx_len, ack0, rx_irq0;
   logic [31:0] rx_ptr, rx_ctrl;
   logic        rx_crc;

   logic [31:0] ar_addr_q [$];
   logic [7:0]  ar_len_q [$];
   logic        ar_busy, w_busy;
   logic [31:0] r_addr, w_addr;
   logic [7:0]  r_len, r_beat, w_len, w_beat;

   eth_dma dut0 (.*);

   always #2 clk_i = ~clk_i;

   function automatic logic [7:0] expect_byte(input logic rx_side, input int k);
      if (rx_side) return rx_buf[k];
      if (k < `ETH_PREAMBLE_LEN) return `ETH_PREAMBLE;
      if (k == `ETH_PREAMBLE_LEN) return `ETH_SFD;
      return sys_mem[12'(tx_ptr + 32'(k - `ETH_PRE_FRAME_LEN))];
   endfunction

   function automatic logic [31:0] expect_status(input logic [31:0] ctrl, input logic rx_side,
                                                 input int len, input logic crc_err);
      logic [31:0] s;
      s = ctrl;
      s[`ETH_BD_READY] = 1'b0;
      if (rx_side) begin
         s[31:`ETH_BD_LEN_LSB] = 16'(len);
         s[`ETH_BD_CRC_ERR]    = crc_err;
      end
      return s;
   endfunction

   function automatic logic [31:0] make_ctrl(input int len, input logic wrap, input logic crc);
      return (32'(len) << `ETH_BD_LEN_LSB) | (32'd1 << `ETH_BD_READY) |
             (32'd1 << `ETH_BD_IRQ) | (32'(wrap) << `ETH_BD_WRAP) | (32'(crc) << `ETH_BD_CRC);
   endfunction

   task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
      if (exp !== act) begin
         $display("ERR %s %s: expected %h, actual %h", test_name, what, exp, act);
         err_cnt++;
         test_err++;
      end
   endtask

   task automatic start_test(input string name);
      test_name = name;
      test_err  = 0;
   endtask

   task automatic end_test();
      test_cnt++;
      if (test_err != 0) fail_cnt++;
      $display("test %s: %s", test_name, (test_err == 0) ? "ok" : "failed");
   endtask

   task automatic post_tx(input int bd, input int len, input logic wrap, input logic [31:0] ptr);
      tx_bd   = bd;
      tx_len  = len;
      tx_ptr  = ptr;
      tx_ctrl = make_ctrl(len, wrap, 1'($urandom));
      send0   = send_cnt;
      tx_irq0 = tx_irq_cnt;
      bd_mem[2*bd+1] <= ptr;
      bd_mem[2*bd]   <= tx_ctrl;
      @(posedge clk_i);
   endtask

   task automatic post_rx(input int bd, input int len, input logic [31:0] ptr);
      rx_bd   = bd;
      rx_len  = len;
      rx_ptr  = ptr;
      rx_crc  = 1'($urandom);
      rx_ctrl = make_ctrl(0, 1'b0, 1'b0);
      ack0    = ack_cnt;
      rx_irq0 = rx_irq_cnt;
      rx_nbytes_i    <= `ETH_BUF_ADDR_W'(len);
      crc_err_i      <= rx_crc;
      rx_data_rcvd_i <= 1'b1;
      bd_mem[2*bd+1] <= ptr;
      bd_mem[2*bd]   <= rx_ctrl;
      @(posedge clk_i);
   endtask

   task automatic check_tx();
      check("send count", 32'd1, 32'(send_cnt - send0));
      check("tx_nbytes", 32'(tx_len + 8), 32'(last_nbytes));
      check("crc_en", 32'(tx_ctrl[`ETH_BD_CRC]), 32'(last_crc));
      check("tx status", expect_status(tx_ctrl, 1'b0, 0, 1'b0), bd_mem[2*tx_bd]);
      for (int k = 8; k < tx_len + 8; k++) begin
         check("tx buffer byte", 32'(expect_byte(1'b0, k)), 32'(tx_buf[k]));
      end
   endtask

   task automatic check_rx();
      check("ack count", 32'd1, 32'(ack_cnt - ack0));
      check("bready", 32'd1, 32'(axi_bready_o));
      check("rx status", expect_status(rx_ctrl, 1'b1, rx_len, rx_crc), bd_mem[2*rx_bd]);
      for (int k = 0; k < rx_len; k++) begin
         check("rx memory byte", 32'(expect_byte(1'b1, k)), 32'(wr_mem[12'(rx_ptr + k)]));
      end
   endtask

   // Watchdog
   always @(posedge clk_i) begin
      cycles <= cycles + 1;
      if (cycles >= TIMEOUT) begin
         $display("Test %s hung with no completion after %0d cycles", test_name, TIMEOUT);
         $display("TESTS FAILED");
         $finish;
      end
   end

   // Descriptor memory, frame buffers and MAC stub
   always @(posedge clk_i) begin
      bd_rdata_i     <= bd_mem[bd_addr_o];
      rx_buf_rdata_i <= rx_buf[rx_buf_addr_o];
      tx_ready_i     <= ($urandom % 8) != 0;
      if (bd_wen_o) bd_mem[bd_addr_o] <= bd_wdata_o;
      if (tx_buf_wen_o) tx_buf[tx_buf_addr_o] <= tx_buf_wdata_o;
      if (send_o) begin
         send_cnt    <= send_cnt + 1;
         last_nbytes <= tx_nbytes_o;
         last_crc    <= crc_en_o;
      end
      if (rcv_ack_o) begin
         ack_cnt        <= ack_cnt + 1;
         rx_data_rcvd_i <= 1'b0;
      end
      if (tx_irq_o) tx_irq_cnt <= tx_irq_cnt + 1;
      if (rx_irq_o) rx_irq_cnt <= rx_irq_cnt + 1;
   end

   // AXI read slave with random stalls
   always @(posedge clk_i) begin
      if (arst_i) begin
         ar_busy = 1'b0;
      end else if (ar_busy) begin
         if (axi_rvalid_i && axi_rready_o) begin
            if (axi_rlast_i) begin
               ar_busy = 1'b0;
            end else begin
               r_addr = r_addr + 1;
               r_beat = r_beat + 1;
            end
         end
      end else if (axi_arvalid_o && axi_arready_i) begin
         ar_busy = 1'b1;
         r_addr  = axi_araddr_o;
         r_len   = axi_arlen_o;
         r_beat  = 8'd0;
         ar_addr_q.push_back(r_addr);
         ar_len_q.push_back(r_len);
      end
      axi_arready_i <= !ar_busy && (($urandom % 4) != 0);
      axi_rvalid_i  <= ar_busy && ((axi_rvalid_i && !axi_rready_o) || (($urandom % 4) != 0));
      axi_rlast_i   <= (r_beat == r_len);
      axi_rdata_i   <= {sys_mem[{r_addr[11:2], 2'd3}], sys_mem[{r_addr[11:2], 2'd2}],
                        sys_mem[{r_addr[11:2], 2'd1}], sys_mem[{r_addr[11:2], 2'd0}]};
   end

   // AXI write slave, checks strobe and last per beat
   always @(posedge clk_i) begin
      if (arst_i) begin
         w_busy = 1'b0;
      end else if (w_busy) begin
         if (axi_wvalid_o && axi_wready_i) begin
            check("wstrb", 32'(4'b0001 << w_addr[1:0]), 32'(axi_wstrb_o));
            check("wlast", 32'(w_beat == w_len), 32'(axi_wlast_o));
            wr_mem[w_addr[11:0]] = axi_wdata_o[{w_addr[1:0], 3'b000} +: 8];
            if (w_beat == w_len) begin
               w_busy = 1'b0;
            end else begin
               w_addr = w_addr + 1;
               w_beat = w_beat + 1;
            end
         end
      end else if (axi_awvalid_o && axi_awready_i) begin
         w_busy = 1'b1;
         w_addr = axi_awaddr_o;
         w_len  = axi_awlen_o;
         w_beat = 8'd0;
      end
      axi_awready_i <= !w_busy && (($urandom % 4) != 0);
      axi_wready_i  <= w_busy && (($urandom % 4) != 0);
   end

   initial begin
      int left;
      int idx;
      void'($urandom(32'hf35231bf));
      arst_i         <= 1'b1;
      tx_en_i        <= 1'b1;
      rx_en_i        <= 1'b1;
      tx_bd_num_i    <= (`ETH_BD_ADDR_W-1)'(TX_BDS);
      bd_rdata_i     <= '0;
      tx_ready_i     <= 1'b0;
      rx_buf_rdata_i <= '0;
      rx_data_rcvd_i <= 1'b0;
      rx_nbytes_i    <= '0;
      crc_err_i      <= 1'b0;
      axi_arready_i  <= 1'b0;
      axi_rdata_i    <= '0;
      axi_rvalid_i   <= 1'b0;
      axi_rlast_i    <= 1'b0;
      axi_awready_i  <= 1'b0;
      axi_wready_i   <= 1'b0;
      for (int i = 0; i < 4096; i++) begin
         sys_mem[i] = 8'($urandom);
         wr_mem[i]  = 8'h00;
      end
      for (int i = 0; i < 2048; i++) begin
         rx_buf[i] = 8'($urandom);
         tx_buf[i] = 8'h00;
      end
      for (int i = 0; i < 256; i++) bd_mem[i] = 32'd0;
      repeat (16) @(posedge clk_i);
      arst_i <= 1'b0;

      start_test("preamble");
      repeat (12) @(posedge clk_i);
      for (int k = 0; k < 8; k++) begin
         check("buffer byte", 32'(expect_byte(1'b0, k)), 32'(tx_buf[k]));
      end
      end_test();

      start_test("single_tx");
      post_tx(0, 1 + $urandom % 64, 1'b0, 32'h100 + $urandom % 64);
      while (tx_irq_cnt == tx_irq0) @(posedge clk_i);
      check_tx();
      end_test();

      start_test("burst_split");
      ar_addr_q.delete();
      ar_len_q.delete();
      post_tx(1, 40, 1'b1, 32'h203);
      while (tx_irq_cnt == tx_irq0) @(posedge clk_i);
      check_tx();
      check("burst count", 32'd3, 32'(ar_addr_q.size()));
      left = 40;
      idx  = 0;
      while (left > 0 && idx < ar_addr_q.size()) begin
         check("burst addr", tx_ptr + 32'(40 - left), ar_addr_q[idx]);
         check("burst len", 32'(((left > 16) ? 16 : left) - 1), 32'(ar_len_q[idx]));
         left = left - ((left > 16) ? 16 : left);
         idx++;
      end
      end_test();

      start_test("single_rx");
      post_rx(TX_BDS, 20 + $urandom % 45, 32'h800 + $urandom % 4);
      while (rx_irq_cnt == rx_irq0) @(posedge clk_i);
      check_rx();
      end_test();

      // Wrap bit on entry 1 sends the transmit ring back to entry 0
      start_test("concurrent");
      post_tx(0, 1 + $urandom % 64, 1'b0, 32'h140 + $urandom % 64);
      post_rx(TX_BDS + 1, 1 + $urandom % 64, 32'ha00 + $urandom % 8);
      while (tx_irq_cnt == tx_irq0 || rx_irq_cnt == rx_irq0) @(posedge clk_i);
      check_tx();
      check_rx();
      end_test();

      start_test("tx_disabled");
      tx_en_i <= 1'b0;
      post_tx(1, 1 + $urandom % 64, 1'b0, 32'h300 + $urandom % 64);
      repeat (300) @(posedge clk_i);
      check("send while disabled", 32'(send0), 32'(send_cnt));
      check("untouched descriptor", tx_ctrl, bd_mem[2]);
      tx_en_i <= 1'b1;
      while (tx_irq_cnt == tx_irq0) @(posedge clk_i);
      check_tx();
      end_test();

      $display("%0d tests run, %0d failed, %0d errors", test_cnt, fail_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* eth_dma.f */
+incdir+.
eth_dma_pkg.sv
eth_bd_arbiter.sv
eth_tx_dma.sv
eth_rx_dma.sv
eth_dma.sv
eth_dma_tb.sv

/* Makefile */
.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --top-module eth_dma_tb -f eth_dma.f -o eth_dma_tb

run: build
	./obj_dir/eth_dma_tb | tee sim.log
	grep -q "TESTS PASSED" sim.log

lint:
	verilator --lint-only --timing -Wall --top-module eth_dma -f eth_dma.f

clean:
	rm -rf obj_dir sim.log
